// ==== design/cache_controller.sv ====
// Cache controller FSM sequencing hits, refills, write-backs and flushes
`timescale 1ns/1ps
`default_nettype none

module cache_controller
    import cache_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        req_valid,
    input  op_e         op,
    output logic        req_ready,
    output logic        resp_valid,
    input  logic        resp_ready,
    input  logic        hit,
    input  logic        is_dirty,
    input  logic        flush_done,
    output logic        wr_en,
    output wr_sel_e     wr_sel,
    output logic        set_valid,
    output logic        set_dirty,
    output logic        index_clear,
    output logic        index_step,
    output logic        flush_mode,
    output logic        arvalid,
    input  logic        arready,
    input  logic        rvalid,
    output logic        rready,
    output logic        awvalid,
    input  logic        awready,
    output logic        wvalid,
    input  logic        wready,
    input  logic        bvalid,
    output logic        bready
);

    ctrl_state_e state, next_state;
    logic wr_req, flush_req;
    logic accept, done;

    assign accept = req_valid && req_ready;
    assign done = resp_valid && resp_ready;
    assign flush_mode = flush_req;

    // Pending operation, held until its response is taken
    always_ff @(posedge clk, negedge reset)
    begin
        if (!reset)
        begin
            wr_req <= 1'b0;
            flush_req <= 1'b0;
        end
        else if (accept)
        begin
            wr_req <= (op == OP_WRITE);
            flush_req <= (op == OP_FLUSH);
        end
        else if (done)
        begin
            wr_req <= 1'b0;
            flush_req <= 1'b0;
        end
    end

    always_ff @(posedge clk, negedge reset)
    begin
        if (!reset)
            state <= IDLE;
        else
            state <= next_state;
    end

    always_comb
    begin
        next_state = state;
        req_ready = 1'b0;
        resp_valid = 1'b0;
        wr_en = 1'b0;
        wr_sel = PROCESSOR_WRITE;
        set_valid = 1'b0;
        set_dirty = 1'b0;
        index_clear = 1'b0;
        index_step = 1'b0;
        arvalid = 1'b0;
        rready = 1'b0;
        awvalid = 1'b0;
        wvalid = 1'b0;
        bready = 1'b0;

        case (state)
            IDLE:
            begin
                req_ready = 1'b1;
                if (req_valid && op == OP_FLUSH)
                begin
                    index_clear = 1'b1;
                    next_state = FLUSH;
                end
                else if (req_valid)
                    next_state = PROCESS_REQUEST;
            end

            PROCESS_REQUEST:
            begin
                if (hit)
                begin
                    resp_valid = 1'b1;
                    if (resp_ready)
                    begin
                        // Write hit updates the line as the response completes
                        wr_en = wr_req;
                        set_valid = 1'b1;
                        set_dirty = 1'b1;
                        next_state = IDLE;
                    end
                end
                else if (is_dirty)
                begin
                    awvalid = 1'b1;
                    wvalid = 1'b1;
                    if (awready && wready)
                        next_state = WRITE_BACK;
                end
                else
                begin
                    arvalid = 1'b1;
                    if (arready)
                        next_state = MEM_READ;
                end
            end

            MEM_READ:
            begin
                rready = 1'b1;
                if (rvalid)
                begin
                    wr_en = 1'b1;
                    wr_sel = MEMORY_WRITE;
                    set_valid = 1'b1;
                    next_state = PROCESS_REQUEST;
                end
            end

            WRITE_BACK:
            begin
                bready = 1'b1;
                if (bvalid)
                begin
                    // Victim is in memory now, drop the line
                    wr_en = 1'b1;
                    index_step = flush_req;
                    next_state = flush_req ? FLUSH : PROCESS_REQUEST;
                end
            end

            FLUSH:
            begin
                if (flush_done)
                begin
                    resp_valid = 1'b1;
                    if (resp_ready)
                        next_state = IDLE;
                end
                else if (is_dirty)
                begin
                    awvalid = 1'b1;
                    wvalid = 1'b1;
                    if (awready && wready)
                        next_state = WRITE_BACK;
                end
                else
                begin
                    wr_en = 1'b1;
                    index_step = 1'b1;
                end
            end

            default:
                next_state = IDLE;
        endcase
    end

endmodule

`default_nettype wire

// ==== design/cache_datapath.sv ====
// Direct-mapped cache datapath with tag, state and data arrays and flush index
`timescale 1ns/1ps
`default_nettype none

module cache_datapath
    import cache_pkg::*;
#(
    parameter int INDEX_BITS = 3
)
(
    input  logic        clk,
    input  logic        reset,
    input  addr_t       addr,
    input  logic        accept,
    input  data_t       wdata,
    input  data_t       mem_rdata,
    input  logic        wr_en,
    input  wr_sel_e     wr_sel,
    input  logic        set_valid,
    input  logic        set_dirty,
    input  logic        index_clear,
    input  logic        index_step,
    input  logic        flush_mode,
    output logic        hit,
    output logic        is_dirty,
    output logic        flush_done,
    output data_t       rdata,
    output addr_t       araddr,
    output addr_t       awaddr,
    output data_t       mem_wdata
);

    localparam int LINES = 1 << INDEX_BITS;
    localparam int TAG_BITS = $bits(addr_t) - INDEX_BITS;

    typedef logic [TAG_BITS-1:0] tag_t;

    addr_t addr_q;
    data_t wdata_q;
    tag_t tag_mem [LINES];
    data_t data_mem [LINES];
    logic [LINES-1:0] valid_q, dirty_q;
    logic [INDEX_BITS:0] flush_cnt;
    logic [INDEX_BITS-1:0] idx;
    tag_t req_tag;

    // Request registers
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            addr_q <= addr;
            wdata_q <= wdata;
        end
    end

    assign req_tag = addr_q[$bits(addr_t)-1:INDEX_BITS];
    // Flush walks the lines by counter instead of request index
    assign idx = flush_mode ? flush_cnt[INDEX_BITS-1:0] : addr_q[INDEX_BITS-1:0];

    assign hit = valid_q[idx] && (tag_mem[idx] == req_tag);
    assign is_dirty = valid_q[idx] && dirty_q[idx];
    assign flush_done = flush_cnt[INDEX_BITS];
    assign rdata = data_mem[idx];
    assign araddr = addr_q;
    assign awaddr = {tag_mem[idx], idx};
    assign mem_wdata = data_mem[idx];

    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            tag_mem[idx] <= req_tag;
            data_mem[idx] <= (wr_sel == MEMORY_WRITE) ? mem_rdata : wdata_q;
        end
    end

    always_ff @(posedge clk, negedge reset)
    begin
        if (!reset)
        begin
            valid_q <= '0;
            dirty_q <= '0;
            flush_cnt <= '0;
        end
        else
        begin
            if (wr_en)
            begin
                valid_q[idx] <= set_valid;
                dirty_q[idx] <= set_dirty;
            end
            if (index_clear)
                flush_cnt <= '0;
            else if (index_step)
                flush_cnt <= flush_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== design/cache_pkg.sv ====
// Shared widths and encodings for the two-port cache memory subsystem
`default_nettype none

package cache_pkg;

    // Word address and data word
    typedef logic [15:0] addr_t;
    typedef logic [31:0] data_t;

    // Processor operation
    typedef enum logic [1:0] {
        OP_READ,
        OP_WRITE,
        OP_FLUSH
    } op_e;

    // Cache controller states
    typedef enum logic [2:0] {
        IDLE,
        PROCESS_REQUEST,
        MEM_READ,
        WRITE_BACK,
        FLUSH
    } ctrl_state_e;

    // Source of data written into a line
    typedef enum logic {
        PROCESSOR_WRITE,
        MEMORY_WRITE
    } wr_sel_e;

endpackage

`default_nettype wire

// ==== design/cache_system.sv ====
// Two-port cache subsystem sharing one main memory through an arbiter
`timescale 1ns/1ps
`default_nettype none

module cache_system
    import cache_pkg::*;
#(
    parameter int INDEX_BITS = 3,
    parameter int MEM_WORDS = 1024
)
(
    input  logic    clk,
    input  logic    reset,
    input  logic    req_valid_0,
    input  op_e     op_0,
    input  addr_t   addr_0,
    input  data_t   wdata_0,
    output logic    req_ready_0,
    output logic    resp_valid_0,
    output data_t   rdata_0,
    input  logic    resp_ready_0,
    input  logic    req_valid_1,
    input  op_e     op_1,
    input  addr_t   addr_1,
    input  data_t   wdata_1,
    output logic    req_ready_1,
    output logic    resp_valid_1,
    output data_t   rdata_1,
    input  logic    resp_ready_1
);

    logic hit_0, dirty_0, flush_done_0, wr_en_0, set_valid_0, set_dirty_0;
    logic hit_1, dirty_1, flush_done_1, wr_en_1, set_valid_1, set_dirty_1;
    logic index_clear_0, index_step_0, flush_mode_0;
    logic index_clear_1, index_step_1, flush_mode_1;
    wr_sel_e wr_sel_0, wr_sel_1;
    addr_t araddr_0, awaddr_0, araddr_1, awaddr_1, m_araddr, m_awaddr;
    data_t mem_rdata_0, mem_wdata_0, mem_rdata_1, mem_wdata_1, m_rdata, m_wdata;
    logic arvalid_0, arready_0, rvalid_0, rready_0, awvalid_0, awready_0;
    logic wvalid_0, wready_0, bvalid_0, bready_0;
    logic arvalid_1, arready_1, rvalid_1, rready_1, awvalid_1, awready_1;
    logic wvalid_1, wready_1, bvalid_1, bready_1;
    logic m_arvalid, m_arready, m_rvalid, m_rready, m_awvalid, m_awready;
    logic m_wvalid, m_wready, m_bvalid, m_bready;

    // Request handshake loads the datapath registers
    wire accept_0 = req_valid_0 && req_ready_0;
    wire accept_1 = req_valid_1 && req_ready_1;

    cache_controller ctrl_0 (
        .clk(clk), .reset(reset), .req_valid(req_valid_0), .op(op_0),
        .req_ready(req_ready_0), .resp_valid(resp_valid_0), .resp_ready(resp_ready_0),
        .hit(hit_0), .is_dirty(dirty_0), .flush_done(flush_done_0),
        .wr_en(wr_en_0), .wr_sel(wr_sel_0), .set_valid(set_valid_0),
        .set_dirty(set_dirty_0), .index_clear(index_clear_0),
        .index_step(index_step_0), .flush_mode(flush_mode_0),
        .arvalid(arvalid_0), .arready(arready_0), .rvalid(rvalid_0), .rready(rready_0),
        .awvalid(awvalid_0), .awready(awready_0), .wvalid(wvalid_0), .wready(wready_0),
        .bvalid(bvalid_0), .bready(bready_0)
    );

    cache_datapath #(.INDEX_BITS(INDEX_BITS)) dp_0 (
        .clk(clk), .reset(reset), .addr(addr_0), .accept(accept_0), .wdata(wdata_0),
        .mem_rdata(mem_rdata_0), .wr_en(wr_en_0), .wr_sel(wr_sel_0),
        .set_valid(set_valid_0), .set_dirty(set_dirty_0), .index_clear(index_clear_0),
        .index_step(index_step_0), .flush_mode(flush_mode_0),
        .hit(hit_0), .is_dirty(dirty_0), .flush_done(flush_done_0), .rdata(rdata_0),
        .araddr(araddr_0), .awaddr(awaddr_0), .mem_wdata(mem_wdata_0)
    );

    cache_controller ctrl_1 (
        .clk(clk), .reset(reset), .req_valid(req_valid_1), .op(op_1),
        .req_ready(req_ready_1), .resp_valid(resp_valid_1), .resp_ready(resp_ready_1),
        .hit(hit_1), .is_dirty(dirty_1), .flush_done(flush_done_1),
        .wr_en(wr_en_1), .wr_sel(wr_sel_1), .set_valid(set_valid_1),
        .set_dirty(set_dirty_1), .index_clear(index_clear_1),
        .index_step(index_step_1), .flush_mode(flush_mode_1),
        .arvalid(arvalid_1), .arready(arready_1), .rvalid(rvalid_1), .rready(rready_1),
        .awvalid(awvalid_1), .awready(awready_1), .wvalid(wvalid_1), .wready(wready_1),
        .bvalid(bvalid_1), .bready(bready_1)
    );

    cache_datapath #(.INDEX_BITS(INDEX_BITS)) dp_1 (
        .clk(clk), .reset(reset), .addr(addr_1), .accept(accept_1), .wdata(wdata_1),
        .mem_rdata(mem_rdata_1), .wr_en(wr_en_1), .wr_sel(wr_sel_1),
        .set_valid(set_valid_1), .set_dirty(set_dirty_1), .index_clear(index_clear_1),
        .index_step(index_step_1), .flush_mode(flush_mode_1),
        .hit(hit_1), .is_dirty(dirty_1), .flush_done(flush_done_1), .rdata(rdata_1),
        .araddr(araddr_1), .awaddr(awaddr_1), .mem_wdata(mem_wdata_1)
    );

    mem_arbiter arbiter (
        .clk(clk), .reset(reset),
        .araddr_0(araddr_0), .awaddr_0(awaddr_0), .wdata_0(mem_wdata_0),
        .rdata_0(mem_rdata_0), .arvalid_0(arvalid_0), .rready_0(rready_0),
        .awvalid_0(awvalid_0), .wvalid_0(wvalid_0), .bready_0(bready_0),
        .arready_0(arready_0), .rvalid_0(rvalid_0), .awready_0(awready_0),
        .wready_0(wready_0), .bvalid_0(bvalid_0),
        .araddr_1(araddr_1), .awaddr_1(awaddr_1), .wdata_1(mem_wdata_1),
        .rdata_1(mem_rdata_1), .arvalid_1(arvalid_1), .rready_1(rready_1),
        .awvalid_1(awvalid_1), .wvalid_1(wvalid_1), .bready_1(bready_1),
        .arready_1(arready_1), .rvalid_1(rvalid_1), .awready_1(awready_1),
        .wready_1(wready_1), .bvalid_1(bvalid_1),
        .m_araddr(m_araddr), .m_awaddr(m_awaddr), .m_wdata(m_wdata), .m_rdata(m_rdata),
        .m_arvalid(m_arvalid), .m_rready(m_rready), .m_awvalid(m_awvalid),
        .m_wvalid(m_wvalid), .m_bready(m_bready), .m_arready(m_arready),
        .m_rvalid(m_rvalid), .m_awready(m_awready), .m_wready(m_wready),
        .m_bvalid(m_bvalid)
    );

    main_memory #(.MEM_WORDS(MEM_WORDS)) memory (
        .clk(clk), .araddr(m_araddr), .arvalid(m_arvalid), .arready(m_arready),
        .rdata(m_rdata), .rvalid(m_rvalid), .rready(m_rready),
        .awaddr(m_awaddr), .awvalid(m_awvalid), .awready(m_awready),
        .wdata(m_wdata), .wvalid(m_wvalid), .wready(m_wready),
        .bvalid(m_bvalid), .bready(m_bready), .reset(reset)
    );

endmodule

`default_nettype wire

// ==== design/main_memory.sv ====
// Word-wide main memory behind an AXI4-lite style slave handshake
`timescale 1ns/1ps
`default_nettype none

module main_memory
    import cache_pkg::*;
#(
    parameter int MEM_WORDS = 1024
)
(
    input  logic    clk,
    input  addr_t   araddr,
    input  logic    arvalid,
    output logic    arready,
    output data_t   rdata,
    output logic    rvalid,
    input  logic    rready,
    input  addr_t   awaddr,
    input  logic    awvalid,
    output logic    awready,
    input  data_t   wdata,
    input  logic    wvalid,
    output logic    wready,
    output logic    bvalid,
    input  logic    bready,
    input  logic    reset
);

    localparam int ADDR_BITS = $clog2(MEM_WORDS);

    data_t mem [MEM_WORDS];
    logic r_pend, b_pend;
    logic idle;

    // One transaction in flight at a time
    assign idle = !r_pend && !b_pend;
    assign arready = idle;
    assign awready = idle;
    assign wready = idle;
    assign rvalid = r_pend;
    assign bvalid = b_pend;

    always_ff @(posedge clk)
    begin
        if (arvalid && arready)
            rdata <= mem[araddr[ADDR_BITS-1:0]];
        if (awvalid && awready && wvalid && wready)
            mem[awaddr[ADDR_BITS-1:0]] <= wdata;
    end

    always_ff @(posedge clk, negedge reset)
    begin
        if (!reset)
        begin
            r_pend <= 1'b0;
            b_pend <= 1'b0;
        end
        else
        begin
            if (arvalid && arready)
                r_pend <= 1'b1;
            else if (rready)
                r_pend <= 1'b0;
            if (awvalid && awready && wvalid && wready)
                b_pend <= 1'b1;
            else if (bready)
                b_pend <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== design/mem_arbiter.sv ====
// Round-robin arbiter granting the shared memory channels to one cache at a time
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter
    import cache_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  addr_t   araddr_0, awaddr_0,
    input  data_t   wdata_0,
    output data_t   rdata_0,
    input  logic    arvalid_0, rready_0, awvalid_0, wvalid_0, bready_0,
    output logic    arready_0, rvalid_0, awready_0, wready_0, bvalid_0,
    input  addr_t   araddr_1, awaddr_1,
    input  data_t   wdata_1,
    output data_t   rdata_1,
    input  logic    arvalid_1, rready_1, awvalid_1, wvalid_1, bready_1,
    output logic    arready_1, rvalid_1, awready_1, wready_1, bvalid_1,
    output addr_t   m_araddr, m_awaddr,
    output data_t   m_wdata,
    input  data_t   m_rdata,
    output logic    m_arvalid, m_rready, m_awvalid, m_wvalid, m_bready,
    input  logic    m_arready, m_rvalid, m_awready, m_wready, m_bvalid
);

    // One-hot grant, zero when the bus is free
    logic [1:0] grant_q;
    logic last_q;
    logic req_0, req_1, release_bus;

    assign req_0 = arvalid_0 || awvalid_0;
    assign req_1 = arvalid_1 || awvalid_1;
    assign release_bus = (m_rvalid && m_rready) || (m_bvalid && m_bready);

    always_ff @(posedge clk, negedge reset)
    begin
        if (!reset)
        begin
            grant_q <= 2'b00;
            last_q <= 1'b1;
        end
        else if (grant_q == 2'b00)
        begin
            // Cache 0 wins a tie unless it won last
            if (req_0 && (!req_1 || last_q))
            begin
                grant_q <= 2'b01;
                last_q <= 1'b0;
            end
            else if (req_1)
            begin
                grant_q <= 2'b10;
                last_q <= 1'b1;
            end
        end
        else if (release_bus)
            grant_q <= 2'b00;
    end

    assign m_araddr = grant_q[1] ? araddr_1 : araddr_0;
    assign m_awaddr = grant_q[1] ? awaddr_1 : awaddr_0;
    assign m_wdata = grant_q[1] ? wdata_1 : wdata_0;
    assign m_arvalid = (grant_q[0] && arvalid_0) || (grant_q[1] && arvalid_1);
    assign m_rready = (grant_q[0] && rready_0) || (grant_q[1] && rready_1);
    assign m_awvalid = (grant_q[0] && awvalid_0) || (grant_q[1] && awvalid_1);
    assign m_wvalid = (grant_q[0] && wvalid_0) || (grant_q[1] && wvalid_1);
    assign m_bready = (grant_q[0] && bready_0) || (grant_q[1] && bready_1);

    // Responses reach the granted cache only
    assign rdata_0 = m_rdata;
    assign rdata_1 = m_rdata;
    assign arready_0 = grant_q[0] && m_arready;
    assign rvalid_0 = grant_q[0] && m_rvalid;
    assign awready_0 = grant_q[0] && m_awready;
    assign wready_0 = grant_q[0] && m_wready;
    assign bvalid_0 = grant_q[0] && m_bvalid;
    assign arready_1 = grant_q[1] && m_arready;
    assign rvalid_1 = grant_q[1] && m_rvalid;
    assign awready_1 = grant_q[1] && m_awready;
    assign wready_1 = grant_q[1] && m_wready;
    assign bvalid_1 = grant_q[1] && m_bvalid;

endmodule

`default_nettype wire

// ==== dv/cache_system_checker.sv ====
// Grant and channel handshake assertions for the memory arbiter and cache controllers
`timescale 1ns/1ps
`default_nettype none

module cache_system_checker
(
    input  logic        clk,
    input  logic        reset,
    input  logic [1:0]  grant,
    input  logic        arvalid,
    input  logic        arready,
    input  logic        awvalid,
    input  logic        awready,
    input  logic        wvalid,
    input  logic        wready,
    input  logic        rvalid,
    input  logic        rready,
    input  logic        bvalid,
    input  logic        bready
);

    // At most one cache owns the memory channels
    assert property (@(posedge clk) disable iff (!reset) !(grant[0] && grant[1]))
        else $error("both caches granted at once");

    // Requests hold until accepted
    assert property (@(posedge clk) disable iff (!reset) arvalid && !arready |=> arvalid)
        else $error("arvalid dropped before arready");

    assert property (@(posedge clk) disable iff (!reset) awvalid && !awready |=> awvalid)
        else $error("awvalid dropped before awready");

    assert property (@(posedge clk) disable iff (!reset) wvalid && !wready |=> wvalid)
        else $error("wvalid dropped before wready");

    // Responses hold until taken
    assert property (@(posedge clk) disable iff (!reset) rvalid && !rready |=> rvalid)
        else $error("rvalid dropped before rready");

    assert property (@(posedge clk) disable iff (!reset) bvalid && !bready |=> bvalid)
        else $error("bvalid dropped before bready");

endmodule

`default_nettype wire

// ==== dv/cache_system_tb.sv ====
// Testbench for the two-port cache subsystem with shadow memory and response assertions
`timescale 1ns/1ps
`default_nettype none

module cache_system_tb
    import cache_pkg::*;
();

    localparam int TIMEOUT = 300;
    localparam int RAND_OPS = 40;

    logic clk, reset;
    logic req_valid [2];
    op_e op [2];
    addr_t addr [2];
    data_t wdata [2];
    logic req_ready [2];
    logic resp_valid [2];
    data_t rdata [2];
    logic resp_ready [2];

    // Expected response of the request in flight on each port
    data_t exp_data [2];
    logic check_read [2];
    logic want_hit [2];
    logic want_miss [2];

    data_t shadow [1024];
    logic [1023:0] written;
    logic [31:0] lcg_state;
    string test_name;
    op_e rnd_op [2][RAND_OPS];
    addr_t rnd_addr [2][RAND_OPS];
    data_t rnd_data [2][RAND_OPS];

    cache_system #(.INDEX_BITS(3), .MEM_WORDS(1024)) DUT (
        .clk(clk), .reset(reset),
        .req_valid_0(req_valid[0]), .op_0(op[0]), .addr_0(addr[0]), .wdata_0(wdata[0]),
        .req_ready_0(req_ready[0]), .resp_valid_0(resp_valid[0]), .rdata_0(rdata[0]),
        .resp_ready_0(resp_ready[0]),
        .req_valid_1(req_valid[1]), .op_1(op[1]), .addr_1(addr[1]), .wdata_1(wdata[1]),
        .req_ready_1(req_ready[1]), .resp_valid_1(resp_valid[1]), .rdata_1(rdata[1]),
        .resp_ready_1(resp_ready[1])
    );

    // A cache sees memory readiness or a response only while it holds the grant
    bind mem_arbiter cache_system_checker arbiter_check (
        .clk(clk), .reset(reset),
        .grant({arready_1 || awready_1 || wready_1 || rvalid_1 || bvalid_1,
                arready_0 || awready_0 || wready_0 || rvalid_0 || bvalid_0}),
        .arvalid(m_arvalid), .arready(m_arready), .awvalid(m_awvalid), .awready(m_awready),
        .wvalid(m_wvalid), .wready(m_wready), .rvalid(m_rvalid), .rready(m_rready),
        .bvalid(m_bvalid), .bready(m_bready)
    );

    bind cache_controller cache_system_checker ctrl_check (
        .clk(clk), .reset(reset), .grant(2'b00),
        .arvalid(arvalid), .arready(arready), .awvalid(awvalid), .awready(awready),
        .wvalid(wvalid), .wready(wready), .rvalid(rvalid), .rready(rready),
        .bvalid(bvalid), .bready(bready)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic stop_with_failure(input string what);
        $display("%s", what);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    // Idle outputs while reset is held and right after
    assert property (@(posedge clk) !reset |=> req_ready[0] && req_ready[1]
                     && !resp_valid[0] && !resp_valid[1]
                     && !DUT.m_arvalid && !DUT.m_awvalid && !DUT.m_wvalid)
        else stop_with_failure("port or memory outputs were not idle after reset");

    for (genvar p = 0; p < 2; p++)
    begin : g_port_checks
        assert property (@(posedge clk) disable iff (!reset)
                         resp_valid[p] && resp_ready[p] && check_read[p]
                         |-> rdata[p] == exp_data[p])
            else stop_with_failure($sformatf("** Error %s: port %0d expected %h, actual %h",
                                             test_name, p, $sampled(exp_data[p]),
                                             $sampled(rdata[p])));

        assert property (@(posedge clk) disable iff (!reset)
                         req_valid[p] && req_ready[p] && want_hit[p] |=> resp_valid[p])
            else stop_with_failure($sformatf("%s: port %0d hit did not answer next cycle",
                                             test_name, p));

        assert property (@(posedge clk) disable iff (!reset)
                         req_valid[p] && req_ready[p] && want_miss[p] |=> !resp_valid[p])
            else stop_with_failure($sformatf("%s: port %0d answered a miss like a hit",
                                             test_name, p));

        // Back-pressure keeps the response steady
        assert property (@(posedge clk) disable iff (!reset)
                         resp_valid[p] && !resp_ready[p] |=> resp_valid[p] && $stable(rdata[p]))
            else stop_with_failure($sformatf("%s: port %0d response changed while stalled",
                                             test_name, p));

        // One response per request
        assert property (@(posedge clk) disable iff (!reset)
                         resp_valid[p] && resp_ready[p] |=> !resp_valid[p])
            else stop_with_failure($sformatf("%s: port %0d gave a second response",
                                             test_name, p));
    end

    task automatic issue_request(input int p, input op_e kind, input addr_t a, input data_t d,
                                 input logic hit_exp, input logic miss_exp, input int stall);
        int cycles;
        if (kind == OP_WRITE)
        begin
            shadow[a[9:0]] = d;
            written[a[9:0]] = 1'b1;
        end
        @(posedge clk);
        req_valid[p] <= 1'b1;
        op[p] <= kind;
        addr[p] <= a;
        wdata[p] <= d;
        exp_data[p] <= shadow[a[9:0]];
        check_read[p] <= (kind == OP_READ);
        want_hit[p] <= hit_exp;
        want_miss[p] <= miss_exp;
        resp_ready[p] <= (stall == 0);
        cycles = 0;
        do
        begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT)
                stop_with_failure($sformatf("%s: port %0d request never accepted", test_name, p));
        end while (!req_ready[p]);
        @(posedge clk);
        req_valid[p] <= 1'b0;
        cycles = 0;
        do
        begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT)
                stop_with_failure($sformatf("%s: port %0d response never came", test_name, p));
        end while (!resp_valid[p]);
        if (stall > 0)
        begin
            repeat (stall) @(posedge clk);
            resp_ready[p] <= 1'b1;
        end
        @(posedge clk);
    endtask

    task automatic drive_random_ops(input int p);
        for (int i = 0; i < RAND_OPS; i++)
            issue_request(p, rnd_op[p][i], rnd_addr[p][i], rnd_data[p][i], 1'b0, 1'b0, i % 3);
    endtask

    initial
    begin
        logic [31:0] r;
        addr_t a;
        op_e k;
        reset = 1'b1;
        for (int p = 0; p < 2; p++)
        begin
            req_valid[p] = 1'b0;
            op[p] = OP_READ;
            addr[p] = '0;
            wdata[p] = '0;
            resp_ready[p] = 1'b1;
            exp_data[p] = '0;
            check_read[p] = 1'b0;
            want_hit[p] = 1'b0;
            want_miss[p] = 1'b0;
        end
        lcg_state = 32'd23;
        written = '0;
        test_name = "reset";
        @(posedge clk);
        reset <= 1'b0;
        repeat (3) @(posedge clk);
        reset <= 1'b1;

        test_name = "write_read_hit";
        issue_request(0, OP_WRITE, 16'h0010, 32'h1111_0010, 1'b0, 1'b0, 0);
        issue_request(0, OP_READ, 16'h0010, '0, 1'b1, 1'b0, 0);
        issue_request(1, OP_WRITE, 16'h0210, 32'h2222_0210, 1'b0, 1'b0, 0);
        issue_request(1, OP_READ, 16'h0210, '0, 1'b1, 1'b0, 0);

        // Index 5 under two different tags
        test_name = "evict_refill";
        issue_request(0, OP_WRITE, 16'h0005, 32'h1111_0005, 1'b0, 1'b0, 0);
        issue_request(0, OP_WRITE, 16'h0045, 32'h1111_0045, 1'b0, 1'b0, 0);
        issue_request(0, OP_READ, 16'h0005, '0, 1'b0, 1'b1, 0);

        test_name = "back_pressure";
        issue_request(0, OP_READ, 16'h0005, '0, 1'b1, 1'b0, 4);

        test_name = "flush";
        issue_request(0, OP_FLUSH, '0, '0, 1'b0, 1'b0, 0);
        issue_request(0, OP_READ, 16'h0010, '0, 1'b0, 1'b1, 0);
        issue_request(0, OP_READ, 16'h0045, '0, 1'b0, 1'b1, 0);
        issue_request(1, OP_FLUSH, '0, '0, 1'b0, 1'b0, 2);
        issue_request(1, OP_READ, 16'h0210, '0, 1'b0, 1'b1, 0);

        // Sixteen addresses per port with four tags per index
        test_name = "random_traffic";
        for (int i = 0; i < RAND_OPS; i++)
        begin
            for (int p = 0; p < 2; p++)
            begin
                r = lcg_next();
                a = addr_t'(p * 512 + ((r >> 20) % 4) * 8 + ((r >> 24) % 4));
                if (r[7:4] == 4'd0)
                    k = OP_FLUSH;
                else if (r[9] && written[a[9:0]])
                    k = OP_READ;
                else
                    k = OP_WRITE;
                if (k == OP_WRITE)
                    written[a[9:0]] = 1'b1;
                rnd_op[p][i] = k;
                rnd_addr[p][i] = a;
                rnd_data[p][i] = lcg_next();
            end
        end
        fork
            drive_random_ops(0);
            drive_random_ops(1);
        join

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# Compile and run the two-port cache testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f src.f --top-module cache_system_tb -o cache_system_sim

./obj_dir/cache_system_sim

// ==== src.f ====
design/cache_pkg.sv
design/cache_controller.sv
design/cache_datapath.sv
design/mem_arbiter.sv
design/main_memory.sv
design/cache_system.sv
dv/cache_system_checker.sv
dv/cache_system_tb.sv
